// File: project.f
verilog/cpu_pkg.sv
verilog/alu.sv
verilog/fetch_stage.sv
verilog/decoder.sv
verilog/reg_file.sv
verilog/execute_stage.sv
verilog/hazard_unit.sv
verilog/writeback_stage.sv
verilog/cpu.sv
bench/tb_memory.sv
bench/tb_cpu.sv

// File: bench/tb_cpu.sv
module tb_cpu;
    timeunit 1ns;
    timeprecision 1ps;

    localparam logic [31:0] MARK_ADDR   = 32'h0000_00f0;
    localparam logic [31:0] DONE_ADDR   = 32'h0000_00f8;
    localparam logic [31:0] POISON_ADDR = 32'h0000_00fc;

    logic clk = 1'b0;
    logic reset;
    logic [31:0] im_addr, im_dout, mem_addr, mem_din, mem_dout;
    logic mem_we;

    logic [31:0] exp_addr [64];
    logic [31:0] exp_data [64];
    logic [31:0] data_copy [16];
    logic [31:0] x [32];
    int n_exp, idx, fails, fails_seen, tests_passed, tests_failed, cycles, limit;
    logic started, done;
    logic [31:0] mark_seen;

    cpu #(.RESET_VECTOR(32'h0)) u_dut (
        .clk(clk), .reset(reset),
        .im_addr(im_addr), .im_dout(im_dout),
        .mem_addr(mem_addr), .mem_we(mem_we), .mem_din(mem_din), .mem_dout(mem_dout)
    );

    tb_memory u_mem (
        .clk(clk), .im_addr(im_addr), .im_dout(im_dout),
        .mem_addr(mem_addr), .mem_we(mem_we), .mem_din(mem_din), .mem_dout(mem_dout)
    );

    always #2 clk = ~clk;

    task automatic push_store(input logic [31:0] a, input logic [31:0] d);
        exp_addr[n_exp] = a;
        exp_data[n_exp] = d;
        n_exp++;
    endtask

    // Expected stores in program order, by RV32I semantics
    task automatic build_expected();
        logic [4:0] sh;
        int alu_regs [21] = '{3, 4, 5, 6, 7, 8, 9, 10, 11, 12,
                              26, 27, 28, 29, 30, 31, 13, 14, 15, 20, 21};
        for (int i = 0; i < 16; i++)
            data_copy[i] = u_mem.ram[i];
        x[1] = data_copy[0];
        x[2] = data_copy[1];
        sh = x[2][4:0];
        x[3] = x[1] + x[2];
        x[4] = x[3] - x[1];
        x[5] = x[4] & x[3];
        x[6] = x[5] | x[2];
        x[7] = x[6] ^ x[4];
        x[8] = ($signed(x[7]) < $signed(x[1])) ? 32'd1 : 32'd0;
        x[9] = (x[7] < x[1]) ? 32'd1 : 32'd0;
        x[10] = x[7] << sh;
        x[11] = x[7] >> sh;
        x[12] = $signed(x[7]) >>> sh;
        x[26] = x[12] + 32'hffff_fffb;
        x[27] = ($signed(x[26]) < -100) ? 32'd1 : 32'd0;
        x[28] = (x[26] < 32'd100) ? 32'd1 : 32'd0;
        x[29] = x[26] ^ 32'h0000_05a5;
        x[30] = x[29] | 32'hffff_ff00;
        x[31] = x[30] & 32'h0000_07f0;
        x[13] = x[26] << 7;
        x[14] = x[26] >> 9;
        x[15] = $signed(x[26]) >>> 3;
        x[20] = 32'habcd_e000;
        x[21] = u_mem.auipc_pc + 32'h1234_5000;
        foreach (alu_regs[i])
            push_store(32'h40 + 4 * i, x[alu_regs[i]]);
        push_store(MARK_ADDR, 2);
        push_store(32'ha0, data_copy[7] + 32'h123);   // Loaded word plus constant
        push_store(MARK_ADDR, 3);
        push_store(32'ha4, 6);   // Not-taken count
        push_store(32'ha8, 6);   // Taken count
        push_store(MARK_ADDR, 4);
        push_store(32'hac, u_mem.jal_pc + 4);
        push_store(32'hb0, u_mem.jalr_pc + 4);
        push_store(MARK_ADDR, 5);
        push_store(DONE_ADDR, 32'h600);
    endtask

    function automatic string test_name(input int n);
        case (n)
            1:       return "reset";
            2:       return "alu and forwarding";
            3:       return "load-use";
            4:       return "branches";
            5:       return "jumps";
            default: return "completion";
        endcase
    endfunction

    task automatic report_test(input int n);
        if (fails == fails_seen) begin
            tests_passed++;
            $display("test %0d %s: ok", n, test_name(n));
        end else begin
            tests_failed++;
            $display("test %0d %s: FAILED with %0d errors", n, test_name(n), fails - fails_seen);
        end
        fails_seen = fails;
    endtask

    always @(posedge clk) begin
        cycles    <= cycles + 1;
        started   <= 1'b1;
        mark_seen <= '0;
        if (!reset && mem_we) begin
            idx <= idx + 1;
            if (mem_addr == MARK_ADDR)
                mark_seen <= exp_data[idx];
            if (mem_addr == DONE_ADDR)
                done <= 1'b1;
        end
    end

    // Checks of the store at this edge are already done here
    always @(negedge clk) begin
        if (mark_seen != 0)
            report_test(mark_seen);
    end

    reset_quiet: assert property (@(posedge clk) reset && started |-> !mem_we)
        else begin
            $display("mem_we went high while reset was asserted");
            fails++;
        end

    first_cycle_quiet: assert property (@(posedge clk) $fell(reset) |-> !mem_we ##1 !mem_we)
        else begin
            $display("mem_we was high in the first cycle after reset");
            fails++;
        end

    first_fetch: assert property (@(posedge clk) $fell(reset) |-> im_addr == 32'h0)
        else begin
            $display("Mismatch im_addr: got %h expected %h", $sampled(im_addr), 32'h0);
            fails++;
        end

    store_addr: assert property (@(posedge clk) disable iff (reset)
                                 mem_we |-> mem_addr == exp_addr[idx])
        else begin
            $display("Mismatch mem_addr: got %h expected %h",
                     $sampled(mem_addr), exp_addr[$sampled(idx)]);
            fails++;
        end

    store_data: assert property (@(posedge clk) disable iff (reset)
                                 mem_we |-> mem_din == exp_data[idx])
        else begin
            $display("Mismatch mem_din: got %h expected %h",
                     $sampled(mem_din), exp_data[$sampled(idx)]);
            fails++;
        end

    no_poison: assert property (@(posedge clk) disable iff (reset)
                                mem_we |-> mem_addr != POISON_ADDR)
        else begin
            $display("a flushed store after a jump or taken branch reached memory");
            fails++;
        end

    initial begin
        reset = 1'b1;
        started = 1'b0;
        done = 1'b0;
        mark_seen = '0;
        {idx, n_exp, fails, fails_seen, tests_passed, tests_failed, cycles} = '0;
        #1;
        build_expected();
        limit = 8 * u_mem.prog_len + 100;
        repeat (8) @(negedge clk);
        reset = 1'b0;
        @(negedge clk);
        @(negedge clk);
        report_test(1);
        while (!done && cycles < limit)
            @(negedge clk);
        if (done) begin
            report_test(6);
        end else begin
            $display("program did not reach the done store within %0d cycles", limit);
            fails++;
            tests_failed++;
        end
        if (idx != n_exp) begin
            $display("only %0d of %0d expected stores were seen", idx, n_exp);
            fails++;
        end
        $display("tests passed %0d failed %0d", tests_passed, tests_failed);
        if (fails == 0)
            $display("sim passed");
        else
            $display("sim failed");
        $finish;
    end

endmodule

// File: bench/tb_memory.sv
module tb_memory (
    input  logic        clk,
    input  logic [31:0] im_addr,
    output logic [31:0] im_dout,
    input  logic [31:0] mem_addr,
    input  logic        mem_we,
    input  logic [31:0] mem_din,
    output logic [31:0] mem_dout
);
    timeunit 1ns;
    timeprecision 1ps;

    localparam logic [6:0] OPI   = 7'b0010011;
    localparam logic [6:0] LOAD  = 7'b0000011;
    localparam logic [6:0] JALR  = 7'b1100111;
    localparam logic [6:0] LUI   = 7'b0110111;
    localparam logic [6:0] AUIPC = 7'b0010111;

    logic [31:0] rom [128];
    logic [31:0] ram [64];
    int pc, prog_len, auipc_pc, jal_pc, jalr_pc;

    assign im_dout  = rom[im_addr[8:2]];
    assign mem_dout = ram[mem_addr[7:2]];

    always @(posedge clk) begin
        if (mem_we)
            ram[mem_addr[7:2]] <= mem_din;
    end

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return (s >> 1) ^ (s[0] ? 32'h8020_0003 : 32'h0);
    endfunction

    function automatic logic [31:0] r_type(input logic [6:0] f7, input int rs2, input int rs1,
                                           input logic [2:0] f3, input int rd);
        return {f7, 5'(rs2), 5'(rs1), f3, 5'(rd), 7'b0110011};
    endfunction

    function automatic logic [31:0] i_type(input int imm, input int rs1, input logic [2:0] f3,
                                           input int rd, input logic [6:0] opc);
        return {12'(imm), 5'(rs1), f3, 5'(rd), opc};
    endfunction

    // sw rs2, off(x0)
    function automatic logic [31:0] s_word(input int rs2, input int off);
        logic [11:0] o;
        o = 12'(off);
        return {o[11:5], 5'(rs2), 5'd0, 3'b010, o[4:0], 7'b0100011};
    endfunction

    function automatic logic [31:0] b_type(input logic [2:0] f3, input int rs1, input int rs2,
                                           input int off);
        logic [12:0] o;
        o = 13'(off);
        return {o[12], o[10:5], 5'(rs2), 5'(rs1), f3, o[4:1], o[11], 7'b1100011};
    endfunction

    function automatic logic [31:0] jal_word(input int rd, input int off);
        logic [20:0] o;
        o = 21'(off);
        return {o[20], o[10:1], o[11], o[19:12], 5'(rd), 7'b1101111};
    endfunction

    task automatic emit(input logic [31:0] w);
        rom[pc / 4] = w;
        pc += 4;
    endtask

    task automatic mark(input int n);
        emit(i_type(n, 0, 3'd0, 25, OPI));
        emit(s_word(25, 'hf0));
    endtask

    initial begin
        logic [31:0] state;
        logic [31:0] w;
        static int alu_regs [21] = '{3, 4, 5, 6, 7, 8, 9, 10, 11, 12,
                                     26, 27, 28, 29, 30, 31, 13, 14, 15, 20, 21};
        static int br_f3 [6] = '{0, 1, 4, 5, 6, 7};
        static int ta [6] = '{16, 16, 16, 17, 16, 17};
        static int tb [6] = '{16, 17, 17, 16, 17, 16};
        static int na [6] = '{16, 16, 17, 16, 17, 16};
        static int nb [6] = '{17, 16, 16, 17, 16, 17};
        state = 32'h8e07_5989;
        for (int i = 0; i < 16; i++) begin
            for (int b = 0; b < 32; b++) begin
                state = lfsr_next(state);
                w = {w[30:0], state[0]};
            end
            ram[i] = w;
        end
        for (int i = 16; i < 64; i++)
            ram[i] = 32'hc0de_0000 | (i * 4);
        for (int i = 0; i < 128; i++)
            rom[i] = 32'h0000_0013;

        pc = 0;
        emit(i_type(0, 0, 3'd2, 1, LOAD));
        emit(i_type(4, 0, 3'd2, 2, LOAD));
        emit(r_type(7'h00, 2, 1, 3'd0, 3));   // add right behind a load
        emit(r_type(7'h20, 1, 3, 3'd0, 4));
        emit(r_type(7'h00, 3, 4, 3'd7, 5));
        emit(r_type(7'h00, 2, 5, 3'd6, 6));
        emit(r_type(7'h00, 4, 6, 3'd4, 7));
        emit(r_type(7'h00, 1, 7, 3'd2, 8));
        emit(r_type(7'h00, 1, 7, 3'd3, 9));
        emit(r_type(7'h00, 2, 7, 3'd1, 10));
        emit(r_type(7'h00, 2, 7, 3'd5, 11));
        emit(r_type(7'h20, 2, 7, 3'd5, 12));
        emit(i_type(-5, 12, 3'd0, 26, OPI));
        emit(i_type(-100, 26, 3'd2, 27, OPI));
        emit(i_type(100, 26, 3'd3, 28, OPI));
        emit(i_type('h5a5, 26, 3'd4, 29, OPI));
        emit(i_type(-256, 29, 3'd6, 30, OPI));
        emit(i_type('h7f0, 30, 3'd7, 31, OPI));
        emit(i_type(7, 26, 3'd1, 13, OPI));
        emit(i_type(9, 26, 3'd5, 14, OPI));
        emit(i_type('h403, 26, 3'd5, 15, OPI));   // srai by 3
        emit({20'habcde, 5'd20, LUI});
        auipc_pc = pc;
        emit({20'h12345, 5'd21, AUIPC});
        foreach (alu_regs[i])
            emit(s_word(alu_regs[i], 'h40 + 4 * i));
        mark(2);

        emit(i_type(28, 0, 3'd2, 22, LOAD));
        emit(i_type('h123, 22, 3'd0, 23, OPI));
        emit(s_word(23, 'ha0));
        mark(3);

        emit(i_type(2, 1, 3'd5, 16, OPI));   // x16 small enough that x16+1 stays positive
        emit(i_type(1, 16, 3'd0, 17, OPI));
        emit(i_type(0, 0, 3'd0, 18, OPI));
        emit(i_type(0, 0, 3'd0, 19, OPI));
        for (int i = 0; i < 6; i++) begin
            emit(b_type(3'(br_f3[i]), ta[i], tb[i], 12));
            emit(s_word(0, 'hfc));
            emit(s_word(0, 'hfc));
            emit(i_type(1, 19, 3'd0, 19, OPI));
        end
        // Operands that make each condition false
        for (int i = 0; i < 6; i++) begin
            emit(b_type(3'(br_f3[i]), na[i], nb[i], 8));
            emit(i_type(1, 18, 3'd0, 18, OPI));
        end
        emit(s_word(18, 'ha4));
        emit(s_word(19, 'ha8));
        mark(4);

        jal_pc = pc;
        emit(jal_word(13, 12));
        emit(s_word(0, 'hfc));
        emit(s_word(0, 'hfc));
        emit(s_word(13, 'hac));
        emit({20'h0, 5'd15, AUIPC});
        jalr_pc = pc;
        emit(i_type(17, 15, 3'd0, 14, JALR));   // Odd offset, bit 0 gets masked
        emit(s_word(0, 'hfc));
        emit(s_word(0, 'hfc));
        emit(s_word(14, 'hb0));
        mark(5);

        emit(i_type('h600, 0, 3'd0, 24, OPI));
        emit(s_word(24, 'hf8));
        emit(jal_word(0, 0));
        prog_len = pc / 4;
    end

endmodule

// File: verilog/cpu.sv
module cpu #(
    parameter cpu_pkg::word_t RESET_VECTOR = 32'h0000_0000
) (
    input  logic           clk,
    input  logic           reset,
    output cpu_pkg::word_t im_addr,
    input  cpu_pkg::word_t im_dout,
    output cpu_pkg::word_t mem_addr,
    output logic           mem_we,
    output cpu_pkg::word_t mem_din,
    input  cpu_pkg::word_t mem_dout
);
    logic stall_if, stall_id, flush_id, flush_ex;
    logic redirect;
    cpu_pkg::word_t redirect_target;
    cpu_pkg::word_t inst_id, pc_id;

    cpu_pkg::reg_addr_t rs1_id, rs2_id, rd_id;
    logic rs1_used, rs2_used;
    cpu_pkg::word_t imm_id, rd0_id, rd1_id;
    cpu_pkg::alu_op_e alu_op_id;
    logic a_is_pc_id, b_is_imm_id;
    cpu_pkg::br_type_e br_type_id;
    logic jal_id, jalr_id, mem_read_id, mem_write_id, reg_write_id;
    cpu_pkg::wb_sel_e wb_sel_id;

    cpu_pkg::reg_addr_t rs1_ex, rs2_ex, rd_ex, rd_mem, rd_wb;
    logic mem_read_ex, reg_write_mem, reg_write_wb;
    cpu_pkg::fwd_sel_e fwd_a, fwd_b;
    cpu_pkg::wb_sel_e wb_sel_mem;
    cpu_pkg::word_t alu_mem, pc4_mem, wd_wb;

    fetch_stage #(.RESET_VECTOR(RESET_VECTOR)) u_fetch (
        .clk(clk), .reset(reset),
        .stall_if(stall_if), .stall_id(stall_id), .flush_id(flush_id),
        .redirect(redirect), .redirect_target(redirect_target),
        .im_dout(im_dout), .im_addr(im_addr),
        .inst_id(inst_id), .pc_id(pc_id)
    );

    decoder u_decoder (
        .inst(inst_id),
        .rs1(rs1_id), .rs2(rs2_id), .rd(rd_id),
        .rs1_used(rs1_used), .rs2_used(rs2_used),
        .imm(imm_id), .alu_op(alu_op_id),
        .a_is_pc(a_is_pc_id), .b_is_imm(b_is_imm_id), .br_type(br_type_id),
        .jal(jal_id), .jalr(jalr_id), .mem_read(mem_read_id),
        .mem_write(mem_write_id), .reg_write(reg_write_id), .wb_sel(wb_sel_id)
    );

    reg_file u_reg_file (
        .clk(clk), .reset(reset),
        .ra0(rs1_id), .ra1(rs2_id),
        .we(reg_write_wb), .wa(rd_wb), .wd(wd_wb),
        .rd0(rd0_id), .rd1(rd1_id)
    );

    execute_stage u_execute (
        .clk(clk), .reset(reset), .flush_ex(flush_ex),
        .rs1(rs1_id), .rs2(rs2_id), .rd(rd_id), .imm(imm_id), .alu_op(alu_op_id),
        .a_is_pc(a_is_pc_id), .b_is_imm(b_is_imm_id), .br_type(br_type_id),
        .jal(jal_id), .jalr(jalr_id), .mem_read(mem_read_id),
        .mem_write(mem_write_id), .reg_write(reg_write_id), .wb_sel(wb_sel_id),
        .pc_id(pc_id), .rd0(rd0_id), .rd1(rd1_id),
        .fwd_a(fwd_a), .fwd_b(fwd_b), .fwd_wb_data(wd_wb),
        .redirect(redirect), .redirect_target(redirect_target),
        .rs1_ex(rs1_ex), .rs2_ex(rs2_ex), .rd_ex(rd_ex),
        .reg_write_ex(), .mem_read_ex(mem_read_ex),
        .rd_mem(rd_mem), .reg_write_mem(reg_write_mem),
        .mem_addr(mem_addr), .mem_din(mem_din), .mem_we(mem_we),
        .wb_sel_mem(wb_sel_mem), .alu_mem(alu_mem), .pc4_mem(pc4_mem)
    );

    hazard_unit u_hazard (
        .rs1_id(rs1_id), .rs2_id(rs2_id),
        .rs1_used(rs1_used), .rs2_used(rs2_used),
        .rs1_ex(rs1_ex), .rs2_ex(rs2_ex), .rd_ex(rd_ex),
        .mem_read_ex(mem_read_ex), .reg_write_mem(reg_write_mem), .rd_mem(rd_mem),
        .reg_write_wb(reg_write_wb), .rd_wb(rd_wb), .redirect(redirect),
        .fwd_a(fwd_a), .fwd_b(fwd_b),
        .stall_if(stall_if), .stall_id(stall_id),
        .flush_id(flush_id), .flush_ex(flush_ex)
    );

    writeback_stage u_writeback (
        .clk(clk), .reset(reset),
        .rd_mem(rd_mem), .reg_write_mem(reg_write_mem), .wb_sel_mem(wb_sel_mem),
        .alu_mem(alu_mem), .pc4_mem(pc4_mem), .mem_dout(mem_dout),
        .rd_wb(rd_wb), .reg_write_wb(reg_write_wb), .wd_wb(wd_wb)
    );

endmodule

// File: verilog/writeback_stage.sv
module writeback_stage (
    input  logic               clk,
    input  logic               reset,
    input  cpu_pkg::reg_addr_t rd_mem,
    input  logic               reg_write_mem,
    input  cpu_pkg::wb_sel_e   wb_sel_mem,
    input  cpu_pkg::word_t     alu_mem,
    input  cpu_pkg::word_t     pc4_mem,
    input  cpu_pkg::word_t     mem_dout,
    output cpu_pkg::reg_addr_t rd_wb,
    output logic               reg_write_wb,
    output cpu_pkg::word_t     wd_wb
);
    cpu_pkg::wb_sel_e wb_sel_wb;
    cpu_pkg::word_t alu_wb, pc4_wb, load_wb;

    always_ff @(posedge clk) begin
        if (reset)
            reg_write_wb <= 1'b0;
        else
            reg_write_wb <= reg_write_mem;
        rd_wb     <= rd_mem;
        wb_sel_wb <= wb_sel_mem;
        alu_wb    <= alu_mem;
        pc4_wb    <= pc4_mem;
        load_wb   <= mem_dout;   // Read data arrives combinationally
    end

    always_comb begin
        case (wb_sel_wb)
            cpu_pkg::mem:      wd_wb = load_wb;
            cpu_pkg::pc_plus4: wd_wb = pc4_wb;
            default:           wd_wb = alu_wb;
        endcase
    end

endmodule

// File: verilog/hazard_unit.sv
module hazard_unit (
    input  cpu_pkg::reg_addr_t rs1_id,
    input  cpu_pkg::reg_addr_t rs2_id,
    input  logic               rs1_used,
    input  logic               rs2_used,
    input  cpu_pkg::reg_addr_t rs1_ex,
    input  cpu_pkg::reg_addr_t rs2_ex,
    input  cpu_pkg::reg_addr_t rd_ex,
    input  logic               mem_read_ex,
    input  logic               reg_write_mem,
    input  cpu_pkg::reg_addr_t rd_mem,
    input  logic               reg_write_wb,
    input  cpu_pkg::reg_addr_t rd_wb,
    input  logic               redirect,
    output cpu_pkg::fwd_sel_e  fwd_a,
    output cpu_pkg::fwd_sel_e  fwd_b,
    output logic               stall_if,
    output logic               stall_id,
    output logic               flush_id,
    output logic               flush_ex
);
    logic load_use;

    function automatic cpu_pkg::fwd_sel_e pick(input cpu_pkg::reg_addr_t rs);
        if (reg_write_mem && rd_mem != '0 && rd_mem == rs)
            return cpu_pkg::from_mem;   // Youngest result wins
        if (reg_write_wb && rd_wb != '0 && rd_wb == rs)
            return cpu_pkg::from_wb;
        return cpu_pkg::regfile;
    endfunction

    assign fwd_a = pick(rs1_ex);
    assign fwd_b = pick(rs2_ex);

    assign load_use = mem_read_ex && rd_ex != '0 &&
                      ((rs1_used && rs1_id == rd_ex) || (rs2_used && rs2_id == rd_ex));

    assign stall_if = load_use;
    assign stall_id = load_use;
    assign flush_id = redirect;
    assign flush_ex = redirect || load_use;   // Bubble behind a load

    // A load in execute can never be the redirecting instruction
    always_comb begin
        stall_vs_redirect: assert final (!(stall_id && redirect));
    end

endmodule

// File: verilog/execute_stage.sv
module execute_stage (
    input  logic               clk,
    input  logic               reset,
    input  logic               flush_ex,
    input  cpu_pkg::reg_addr_t rs1,
    input  cpu_pkg::reg_addr_t rs2,
    input  cpu_pkg::reg_addr_t rd,
    input  cpu_pkg::word_t     imm,
    input  cpu_pkg::alu_op_e   alu_op,
    input  logic               a_is_pc,
    input  logic               b_is_imm,
    input  cpu_pkg::br_type_e  br_type,
    input  logic               jal,
    input  logic               jalr,
    input  logic               mem_read,
    input  logic               mem_write,
    input  logic               reg_write,
    input  cpu_pkg::wb_sel_e   wb_sel,
    input  cpu_pkg::word_t     pc_id,
    input  cpu_pkg::word_t     rd0,
    input  cpu_pkg::word_t     rd1,
    input  cpu_pkg::fwd_sel_e  fwd_a,
    input  cpu_pkg::fwd_sel_e  fwd_b,
    input  cpu_pkg::word_t     fwd_wb_data,
    output logic               redirect,
    output cpu_pkg::word_t     redirect_target,
    output cpu_pkg::reg_addr_t rs1_ex,
    output cpu_pkg::reg_addr_t rs2_ex,
    output cpu_pkg::reg_addr_t rd_ex,
    output logic               reg_write_ex,
    output logic               mem_read_ex,
    output cpu_pkg::reg_addr_t rd_mem,
    output logic               reg_write_mem,
    output cpu_pkg::word_t     mem_addr,
    output cpu_pkg::word_t     mem_din,
    output logic               mem_we,
    output cpu_pkg::wb_sel_e   wb_sel_mem,
    output cpu_pkg::word_t     alu_mem,
    output cpu_pkg::word_t     pc4_mem
);
    cpu_pkg::word_t pc_ex, imm_ex, rd0_ex, rd1_ex;
    cpu_pkg::alu_op_e alu_op_ex;
    cpu_pkg::br_type_e br_type_ex;
    cpu_pkg::wb_sel_e wb_sel_ex;
    logic a_is_pc_ex, b_is_imm_ex, jal_ex, jalr_ex, mem_write_ex;
    cpu_pkg::word_t fwd_mem_data, src_a, src_b, alu_y;
    logic taken;

    always_ff @(posedge clk) begin
        if (reset || flush_ex) begin
            {reg_write_ex, mem_read_ex, mem_write_ex, jal_ex, jalr_ex} <= '0;
            br_type_ex <= cpu_pkg::none;
        end else begin
            {reg_write_ex, mem_read_ex, mem_write_ex} <= {reg_write, mem_read, mem_write};
            {jal_ex, jalr_ex} <= {jal, jalr};
            br_type_ex <= br_type;
        end
        {rs1_ex, rs2_ex, rd_ex} <= {rs1, rs2, rd};
        {pc_ex, imm_ex, rd0_ex, rd1_ex} <= {pc_id, imm, rd0, rd1};
        {a_is_pc_ex, b_is_imm_ex} <= {a_is_pc, b_is_imm};
        alu_op_ex <= alu_op;
        wb_sel_ex <= wb_sel;
    end

    assign fwd_mem_data = (wb_sel_mem == cpu_pkg::pc_plus4) ? pc4_mem : alu_mem;

    assign src_a = (fwd_a == cpu_pkg::from_mem) ? fwd_mem_data :
                   (fwd_a == cpu_pkg::from_wb)  ? fwd_wb_data  : rd0_ex;
    assign src_b = (fwd_b == cpu_pkg::from_mem) ? fwd_mem_data :
                   (fwd_b == cpu_pkg::from_wb)  ? fwd_wb_data  : rd1_ex;

    alu u_alu (
        .op(alu_op_ex),
        .a(a_is_pc_ex ? pc_ex : src_a),
        .b(b_is_imm_ex ? imm_ex : src_b),
        .y(alu_y)
    );

    always_comb begin
        case (br_type_ex)
            cpu_pkg::eq:  taken = src_a == src_b;
            cpu_pkg::ne:  taken = src_a != src_b;
            cpu_pkg::lt:  taken = $signed(src_a) < $signed(src_b);
            cpu_pkg::ge:  taken = $signed(src_a) >= $signed(src_b);
            cpu_pkg::ltu: taken = src_a < src_b;
            cpu_pkg::geu: taken = src_a >= src_b;
            default:      taken = 1'b0;
        endcase
    end

    assign redirect        = jal_ex || jalr_ex || taken;
    assign redirect_target = jalr_ex ? (alu_y & cpu_pkg::JALR_MASK) : alu_y;

    // Execute to memory register
    always_ff @(posedge clk) begin
        if (reset) begin
            reg_write_mem <= 1'b0;
            mem_we        <= 1'b0;
        end else begin
            reg_write_mem <= reg_write_ex;
            mem_we        <= mem_write_ex;
        end
        rd_mem     <= rd_ex;
        wb_sel_mem <= wb_sel_ex;
        alu_mem    <= alu_y;
        mem_addr   <= alu_y;
        mem_din    <= src_b;   // Store data after forwarding
        pc4_mem    <= pc_ex + 32'd4;
    end

endmodule

// File: verilog/reg_file.sv
module reg_file (
    input  logic               clk,
    input  logic               reset,
    input  cpu_pkg::reg_addr_t ra0,
    input  cpu_pkg::reg_addr_t ra1,
    input  logic               we,
    input  cpu_pkg::reg_addr_t wa,
    input  cpu_pkg::word_t     wd,
    output cpu_pkg::word_t     rd0,
    output cpu_pkg::word_t     rd1
);
    cpu_pkg::word_t regs [31:1];

    always_ff @(posedge clk) begin
        if (we && wa != '0)
            regs[wa] <= wd;
    end

    // Write-first so writeback and decode can share a cycle
    assign rd0 = (ra0 == '0) ? '0 : (we && wa == ra0) ? wd : regs[ra0];
    assign rd1 = (ra1 == '0) ? '0 : (we && wa == ra1) ? wd : regs[ra1];

    // Decoder drops reg_write for rd == x0, writeback must keep it dropped
    no_x0_write: assert property (@(posedge clk) disable iff (reset) we |-> wa != '0);

endmodule

// File: verilog/decoder.sv
module decoder (
    input  cpu_pkg::word_t     inst,
    output cpu_pkg::reg_addr_t rs1,
    output cpu_pkg::reg_addr_t rs2,
    output cpu_pkg::reg_addr_t rd,
    output logic               rs1_used,
    output logic               rs2_used,
    output cpu_pkg::word_t     imm,
    output cpu_pkg::alu_op_e   alu_op,
    output logic               a_is_pc,
    output logic               b_is_imm,
    output cpu_pkg::br_type_e  br_type,
    output logic               jal,
    output logic               jalr,
    output logic               mem_read,
    output logic               mem_write,
    output logic               reg_write,
    output cpu_pkg::wb_sel_e   wb_sel
);
    logic [2:0] funct3;
    cpu_pkg::word_t imm_i, imm_s, imm_b, imm_u, imm_j;

    function automatic cpu_pkg::alu_op_e arith_op(input logic [2:0] f3, input logic alt);
        case (f3)
            3'b000:  return alt ? cpu_pkg::sub : cpu_pkg::add;
            3'b001:  return cpu_pkg::sll;
            3'b010:  return cpu_pkg::slt;
            3'b011:  return cpu_pkg::sltu;
            3'b100:  return cpu_pkg::xor_op;
            3'b101:  return alt ? cpu_pkg::sra : cpu_pkg::srl;
            3'b110:  return cpu_pkg::or_op;
            default: return cpu_pkg::and_op;
        endcase
    endfunction

    assign funct3 = inst[14:12];
    assign rs1    = inst[19:15];
    assign rs2    = inst[24:20];
    assign rd     = inst[11:7];

    assign imm_i = {{20{inst[31]}}, inst[31:20]};
    assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
    assign imm_b = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
    assign imm_u = {inst[31:12], 12'h000};
    assign imm_j = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

    always_comb begin
        rs1_used  = 1'b0;
        rs2_used  = 1'b0;
        imm       = imm_i;
        alu_op    = cpu_pkg::add;
        a_is_pc   = 1'b0;
        b_is_imm  = 1'b1;
        br_type   = cpu_pkg::none;
        jal       = 1'b0;
        jalr      = 1'b0;
        mem_read  = 1'b0;
        mem_write = 1'b0;
        reg_write = 1'b0;
        wb_sel    = cpu_pkg::alu;
        case (cpu_pkg::opcode_e'(inst[6:0]))
            cpu_pkg::op: begin
                {rs1_used, rs2_used, reg_write} = 3'b111;
                b_is_imm = 1'b0;
                alu_op   = arith_op(funct3, inst[30]);
            end
            cpu_pkg::op_imm: begin
                {rs1_used, reg_write} = 2'b11;
                alu_op = arith_op(funct3, inst[30] && funct3 == 3'b101);  // srai only
            end
            cpu_pkg::load: begin
                {rs1_used, mem_read, reg_write} = 3'b111;
                wb_sel = cpu_pkg::mem;
            end
            cpu_pkg::store: begin
                {rs1_used, rs2_used, mem_write} = 3'b111;
                imm = imm_s;
            end
            cpu_pkg::branch: begin
                {rs1_used, rs2_used, a_is_pc} = 3'b111;
                imm = imm_b;
                case (funct3)
                    3'b000:  br_type = cpu_pkg::eq;
                    3'b001:  br_type = cpu_pkg::ne;
                    3'b100:  br_type = cpu_pkg::lt;
                    3'b101:  br_type = cpu_pkg::ge;
                    3'b110:  br_type = cpu_pkg::ltu;
                    3'b111:  br_type = cpu_pkg::geu;
                    default: br_type = cpu_pkg::none;
                endcase
            end
            cpu_pkg::jal: begin
                {a_is_pc, jal, reg_write} = 3'b111;
                imm    = imm_j;
                wb_sel = cpu_pkg::pc_plus4;
            end
            cpu_pkg::jalr: begin
                {rs1_used, jalr, reg_write} = 3'b111;
                wb_sel = cpu_pkg::pc_plus4;
            end
            cpu_pkg::lui: begin
                imm       = imm_u;
                alu_op    = cpu_pkg::pass_b;
                reg_write = 1'b1;
            end
            cpu_pkg::auipc: begin
                {a_is_pc, reg_write} = 2'b11;
                imm = imm_u;
            end
            default: ;
        endcase
        if (rd == '0)
            reg_write = 1'b0;   // x0 is never written
    end

endmodule

// File: verilog/fetch_stage.sv
module fetch_stage #(
    parameter cpu_pkg::word_t RESET_VECTOR = 32'h0000_0000
) (
    input  logic           clk,
    input  logic           reset,
    input  logic           stall_if,
    input  logic           stall_id,
    input  logic           flush_id,
    input  logic           redirect,
    input  cpu_pkg::word_t redirect_target,
    input  cpu_pkg::word_t im_dout,
    output cpu_pkg::word_t im_addr,
    output cpu_pkg::word_t inst_id,
    output cpu_pkg::word_t pc_id
);
    cpu_pkg::word_t pc;

    assign im_addr = pc;

    always_ff @(posedge clk) begin
        if (reset)
            pc <= RESET_VECTOR;
        else if (redirect)
            pc <= redirect_target;   // Resolved in execute
        else if (!stall_if)
            pc <= pc + 32'd4;
    end

    // Fetch to decode register
    always_ff @(posedge clk) begin
        if (reset || flush_id) begin
            inst_id <= cpu_pkg::NOP_INST;
        end else if (!stall_id) begin
            inst_id <= im_dout;
            pc_id   <= pc;
        end
    end

    // Jump targets come from execute, so a bad jalr offset shows up here
    pc_aligned: assert property (@(posedge clk) disable iff (reset) pc[1:0] == 2'b00);

endmodule

// File: verilog/alu.sv
module alu (
    input  cpu_pkg::alu_op_e op,
    input  cpu_pkg::word_t   a,
    input  cpu_pkg::word_t   b,
    output cpu_pkg::word_t   y
);
    logic [4:0] shamt;

    assign shamt = b[4:0];

    always_comb begin
        case (op)
            cpu_pkg::add:    y = a + b;
            cpu_pkg::sub:    y = a - b;
            cpu_pkg::sll:    y = a << shamt;
            cpu_pkg::slt:    y = {31'b0, $signed(a) < $signed(b)};
            cpu_pkg::sltu:   y = {31'b0, a < b};
            cpu_pkg::xor_op: y = a ^ b;
            cpu_pkg::srl:    y = a >> shamt;
            cpu_pkg::sra:    y = $signed(a) >>> shamt;
            cpu_pkg::or_op:  y = a | b;
            cpu_pkg::and_op: y = a & b;
            cpu_pkg::pass_b: y = b;   // lui
            default:         y = '0;
        endcase
    end

endmodule

// File: verilog/cpu_pkg.sv
package cpu_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;

    // Major RV32I opcodes
    typedef enum logic [6:0] {
        op     = 7'b0110011,
        op_imm = 7'b0010011,
        load   = 7'b0000011,
        store  = 7'b0100011,
        branch = 7'b1100011,
        jal    = 7'b1101111,
        jalr   = 7'b1100111,
        lui    = 7'b0110111,
        auipc  = 7'b0010111
    } opcode_e;

    typedef enum logic [3:0] {
        add, sub, sll, slt, sltu, xor_op, srl, sra, or_op, and_op, pass_b
    } alu_op_e;

    typedef enum logic [2:0] {
        none, eq, ne, lt, ge, ltu, geu
    } br_type_e;

    typedef enum logic [1:0] {
        alu, mem, pc_plus4
    } wb_sel_e;

    typedef enum logic [1:0] {
        regfile, from_mem, from_wb
    } fwd_sel_e;

    localparam word_t NOP_INST  = 32'h0000_0013;   // addi x0,x0,0
    localparam word_t JALR_MASK = 32'hffff_fffe;

endpackage
